//--- include/mouse_consts.svh
`ifndef MOUSE_CONSTS_SVH
`define MOUSE_CONSTS_SVH

//////////////////////////////
// Bus mapping
//////////////////////////////

// Address of register 0 (status)
`define MOUSE_BASE_ADDR 8'hA0

// Registers in the bank, base through base+5
`define MOUSE_NUM_REGS 8'd6

//////////////////////////////
// Cursor limits
//////////////////////////////

// Largest reachable position on each axis
`define SCREEN_X_MAX 8'd159
`define SCREEN_Y_MAX 8'd119

// Scale factor 1, deltas pass unchanged
`define SENS_RESET 2'd1

`endif

//--- src/mousePkg.sv
package mousePkg;

  // One serial frame after the receiver
  typedef struct packed {
    logic [7:0] data;
    logic       parityError;
  } ps2Byte;

  // Unpacked three-byte movement report
  typedef struct packed {
    logic [2:0] buttons;    // Bit 0 left, bit 1 right, bit 2 middle
    logic       xSign;
    logic       ySign;
    logic       xOverflow;
    logic       yOverflow;
    logic [7:0] dx;         // Low bits, sign is xSign
    logic [7:0] dy;
  } mousePacket;

  // Result handed to the bus side
  typedef struct packed {
    logic [7:0] posX;
    logic [7:0] posY;
    logic [2:0] buttons;
    logic [7:0] lastDx;     // Scaled, saturated to +-127
  } cursorState;

  typedef enum logic [1:0] {rxIdle, rxData, rxParity, rxStop} rxState;

  typedef enum logic [1:0] {asmHeader, asmSecond, asmThird, asmDeliver} asmState;

  // Offsets from the base address
  typedef enum logic [2:0] {
    regStatus, regPosX, regPosY, regLastDx, regSens, regReserved
  } regIndex;

endpackage

//--- src/ps2Receiver.sv
`timescale 1ns/10ps

module ps2Receiver import mousePkg::*; (
  input  logic   CLK,
  input  logic   RESET,
  input  logic   clkMouse,
  input  logic   dataMouse,
  output ps2Byte rxByte,
  output logic   byteReq,
  input  logic   byteAck
);

  logic [1:0] clkSync;
  logic [1:0] dataSync;
  logic       clkPrev;
  logic       fallEdge;
  rxState     state;
  logic [2:0] bitCount;
  logic [7:0] shiftReg;
  logic       parityBit;
  logic       frameDone;
  logic       loadByte;

  //////////////////////////////
  // Line synchronizers
  //////////////////////////////

  // Idle lines sit high, so reset to 1 to avoid a fake edge
  always_ff @(posedge CLK) begin
    if (RESET) begin
      clkSync  <= 2'b11;
      dataSync <= 2'b11;
      clkPrev  <= 1'b1;
    end else begin
      clkSync  <= {clkSync[0], clkMouse};
      dataSync <= {dataSync[0], dataMouse};
      clkPrev  <= clkSync[1];
    end
  end

  // Mouse drives data on rising, host samples on falling
  assign fallEdge = clkPrev & ~clkSync[1];

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state     <= rxIdle;
      bitCount  <= 3'd0;
      frameDone <= 1'b0;
    end else begin
      frameDone <= 1'b0;
      if (fallEdge) begin
        case (state)
          // Start bit must be low, otherwise ignore the edge
          rxIdle: begin
            if (!dataSync[1]) begin
              state    <= rxData;
              bitCount <= 3'd0;
            end
          end
          rxData: begin
            bitCount <= bitCount + 3'd1;
            if (bitCount == 3'd7) begin
              state <= rxParity;
            end
          end
          rxParity: state <= rxStop;
          // Bad stop bit drops the frame
          rxStop: begin
            state     <= rxIdle;
            frameDone <= dataSync[1];
          end
          default: state <= rxIdle;
        endcase
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge CLK) begin
    if (fallEdge && state == rxData) begin
      shiftReg <= {dataSync[1], shiftReg[7:1]};
    end
    if (fallEdge && state == rxParity) begin
      parityBit <= dataSync[1];
    end
  end

  //////////////////////////////
  // Output handshake
  //////////////////////////////

  // Frame lost if the previous handshake is still open
  assign loadByte = frameDone & ~byteReq & ~byteAck;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      byteReq <= 1'b0;
    end else if (byteReq && byteAck) begin
      byteReq <= 1'b0;
    end else if (loadByte) begin
      byteReq <= 1'b1;
    end
  end

  // Odd parity: ones in data plus parity bit must be odd
  always_ff @(posedge CLK) begin
    if (loadByte) begin
      rxByte.data        <= shiftReg;
      rxByte.parityError <= ~(^{shiftReg, parityBit});
    end
  end

endmodule

//--- src/packetAssembler.sv
`timescale 1ns/10ps

module packetAssembler import mousePkg::*; (
  input  logic       CLK,
  input  logic       RESET,
  input  ps2Byte     rxByte,
  input  logic       byteReq,
  output logic       byteAck,
  output mousePacket packet,
  output logic       pktReq,
  input  logic       pktAck,
  output logic       parityFault
);

  asmState state;
  logic    byteTake;

  // No byte accepted while a packet is waiting downstream
  assign byteTake = byteReq & ~byteAck & (state != asmDeliver);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state       <= asmHeader;
      byteAck     <= 1'b0;
      pktReq      <= 1'b0;
      parityFault <= 1'b0;
    end else begin
      parityFault <= 1'b0;

      // Release ack once sender has dropped req
      if (byteAck && !byteReq) begin
        byteAck <= 1'b0;
      end

      if (byteTake) begin
        byteAck <= 1'b1;
        if (rxByte.parityError) begin
          // Corrupt byte, restart packet search
          parityFault <= 1'b1;
          state       <= asmHeader;
        end else begin
          case (state)
            // Bit 3 is always set in a real header
            asmHeader: state <= rxByte.data[3] ? asmSecond : asmHeader;
            asmSecond: state <= asmThird;
            asmThird: begin
              state  <= asmDeliver;
              pktReq <= 1'b1;
            end
            default: state <= asmHeader;
          endcase
        end
      end

      if (state == asmDeliver) begin
        if (pktReq && pktAck) begin
          pktReq <= 1'b0;
        end else if (!pktReq && !pktAck) begin
          state <= asmHeader;
        end
      end
    end
  end

  //////////////////////////////
  // Packet fields
  //////////////////////////////

  // Header: YO XO YS XS 1 M R L
  always_ff @(posedge CLK) begin
    if (byteTake && !rxByte.parityError) begin
      case (state)
        asmHeader: begin
          packet.buttons   <= rxByte.data[2:0];
          packet.xSign     <= rxByte.data[4];
          packet.ySign     <= rxByte.data[5];
          packet.xOverflow <= rxByte.data[6];
          packet.yOverflow <= rxByte.data[7];
        end
        asmSecond: packet.dx <= rxByte.data;
        asmThird:  packet.dy <= rxByte.data;
        default: ;
      endcase
    end
  end

endmodule

//--- src/positionTracker.sv
`timescale 1ns/10ps

`include "mouse_consts.svh"

module positionTracker import mousePkg::*; (
  input  logic       CLK,
  input  logic       RESET,
  input  mousePacket packet,
  input  logic       pktReq,
  output logic       pktAck,
  input  logic [1:0] sens,
  output cursorState cursor,
  output logic       curReq,
  input  logic       curAck
);

  logic signed [10:0] scaledX;
  logic signed [10:0] scaledY;
  logic               delivered;
  logic               start;

  //////////////////////////////
  // Arithmetic helpers
  //////////////////////////////

  // 9-bit delta widened, then shifted by sensitivity
  function automatic logic signed [10:0] scaleDelta(input logic sign, input logic [7:0] mag,
                                                    input logic ovf, input logic [1:0] sensSel);
    logic signed [10:0] raw;
    raw = {{3{sign}}, mag};
    // Overflowed axis is not trusted
    if (ovf) return '0;
    case (sensSel)
      2'd0:    return raw >>> 1;
      2'd1:    return raw;
      2'd2:    return raw <<< 1;
      default: return raw <<< 2;
    endcase
  endfunction

  function automatic logic [7:0] clampAxis(input logic [7:0] pos,
                                           input logic signed [10:0] delta,
                                           input logic [7:0] maxPos);
    logic signed [11:0] sum;
    sum = $signed({4'b0000, pos}) + $signed({delta[10], delta});
    if (sum < 0) return 8'd0;
    if (sum > $signed({4'b0000, maxPos})) return maxPos;
    return sum[7:0];
  endfunction

  // Limit to +-127 for the 8-bit register
  function automatic logic [7:0] saturate(input logic signed [10:0] delta);
    if (delta > 11'sd127) return 8'h7F;
    if (delta < -11'sd127) return 8'h81;
    return delta[7:0];
  endfunction

  assign scaledX = scaleDelta(packet.xSign, packet.dx, packet.xOverflow, sens);
  assign scaledY = scaleDelta(packet.ySign, packet.dy, packet.yOverflow, sens);

  // New packet, both handshakes idle
  assign start = pktReq & ~pktAck & ~curReq & ~curAck & ~delivered;

  //////////////////////////////
  // Handshake sequencing
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      pktAck    <= 1'b0;
      curReq    <= 1'b0;
      delivered <= 1'b0;
      cursor    <= '0;
    end else if (start) begin
      cursor.posX    <= clampAxis(cursor.posX, scaledX, `SCREEN_X_MAX);
      cursor.posY    <= clampAxis(cursor.posY, scaledY, `SCREEN_Y_MAX);
      cursor.buttons <= packet.buttons;
      cursor.lastDx  <= saturate(scaledX);
      curReq         <= 1'b1;
    end else if (curReq && curAck) begin
      curReq    <= 1'b0;
      delivered <= 1'b1;
    end else if (delivered && !curAck) begin
      // Result handed over, now free the packet
      delivered <= 1'b0;
      pktAck    <= 1'b1;
    end else if (pktAck && !pktReq) begin
      pktAck <= 1'b0;
    end
  end

endmodule

//--- src/mouseBusRegs.sv
`timescale 1ns/10ps

`include "mouse_consts.svh"

module mouseBusRegs import mousePkg::*; (
  input  logic       CLK,
  input  logic       RESET,
  input  cursorState cursor,
  input  logic       curReq,
  output logic       curAck,
  input  logic       parityFault,
  output logic [1:0] sens,
  inout  wire  [7:0] busData,
  input  logic [7:0] busAddr,
  input  logic       busWe,
  output logic       interruptRaise,
  input  logic       interruptAck
);

  cursorState curLatched;
  logic       paritySticky;
  logic       loadCur;
  logic [7:0] addrOffset;
  logic       inRange;
  logic       busDrive;
  logic [7:0] busOut;
  logic [7:0] regBank [`MOUSE_NUM_REGS];

  assign loadCur    = curReq & ~curAck;
  assign addrOffset = busAddr - `MOUSE_BASE_ADDR;
  assign inRange    = (busAddr >= `MOUSE_BASE_ADDR) && (addrOffset < `MOUSE_NUM_REGS);

  //////////////////////////////
  // Cursor intake and interrupt
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      curAck         <= 1'b0;
      curLatched     <= '0;
      interruptRaise <= 1'b0;
      paritySticky   <= 1'b0;
    end else begin
      if (loadCur) begin
        curAck     <= 1'b1;
        curLatched <= cursor;
      end else if (curAck && !curReq) begin
        curAck <= 1'b0;
      end
      // New data wins over a same-cycle ack
      if (loadCur) begin
        interruptRaise <= 1'b1;
      end else if (interruptAck) begin
        interruptRaise <= 1'b0;
      end
      // Sticky until reset
      if (parityFault) begin
        paritySticky <= 1'b1;
      end
    end
  end

  // Only the sens register is writable
  always_ff @(posedge CLK) begin
    if (RESET) begin
      sens <= `SENS_RESET;
    end else if (busWe && inRange && addrOffset[2:0] == regSens) begin
      sens <= busData[1:0];
    end
  end

  //////////////////////////////
  // Register view
  //////////////////////////////

  always_comb begin
    regBank[regStatus]   = {paritySticky, 4'b0000, curLatched.buttons};
    regBank[regPosX]     = curLatched.posX;
    regBank[regPosY]     = curLatched.posY;
    regBank[regLastDx]   = curLatched.lastDx;
    regBank[regSens]     = {6'b000000, sens};
    regBank[regReserved] = 8'h00;
  end

  // Registered read, one edge after the address
  always_ff @(posedge CLK) begin
    if (RESET) begin
      busDrive <= 1'b0;
    end else begin
      busDrive <= inRange & ~busWe;
    end
  end

  always_ff @(posedge CLK) begin
    if (inRange) begin
      busOut <= regBank[addrOffset[2:0]];
    end
  end

  // Let go at once when the processor starts writing
  assign busData = (busDrive && !busWe) ? busOut : 8'hzz;

endmodule

//--- src/mouseDriverTop.sv
`timescale 1ns/10ps

module mouseDriverTop import mousePkg::*; (
  input  logic       CLK,
  input  logic       RESET,
  input  logic       clkMouse,
  input  logic       dataMouse,
  inout  wire  [7:0] busData,
  input  logic [7:0] busAddr,
  input  logic       busWe,
  output logic       interruptRaise,
  input  logic       interruptAck
);

  // Receiver to assembler
  ps2Byte     rxByte;
  logic       byteReq;
  logic       byteAck;
  // Assembler to tracker
  mousePacket packet;
  logic       pktReq;
  logic       pktAck;
  logic       parityFault;
  // Tracker to bus side
  cursorState cursor;
  logic       curReq;
  logic       curAck;
  logic [1:0] sens;

  ps2Receiver uReceiver (
    .CLK       (CLK),
    .RESET     (RESET),
    .clkMouse  (clkMouse),
    .dataMouse (dataMouse),
    .rxByte    (rxByte),
    .byteReq   (byteReq),
    .byteAck   (byteAck)
  );

  packetAssembler uAssembler (
    .CLK         (CLK),
    .RESET       (RESET),
    .rxByte      (rxByte),
    .byteReq     (byteReq),
    .byteAck     (byteAck),
    .packet      (packet),
    .pktReq      (pktReq),
    .pktAck      (pktAck),
    .parityFault (parityFault)
  );

  positionTracker uTracker (
    .CLK    (CLK),
    .RESET  (RESET),
    .packet (packet),
    .pktReq (pktReq),
    .pktAck (pktAck),
    .sens   (sens),
    .cursor (cursor),
    .curReq (curReq),
    .curAck (curAck)
  );

  // Sensitivity flows back from the bus side
  mouseBusRegs uBusRegs (
    .CLK            (CLK),
    .RESET          (RESET),
    .cursor         (cursor),
    .curReq         (curReq),
    .curAck         (curAck),
    .parityFault    (parityFault),
    .sens           (sens),
    .busData        (busData),
    .busAddr        (busAddr),
    .busWe          (busWe),
    .interruptRaise (interruptRaise),
    .interruptAck   (interruptAck)
  );

endmodule

//--- tests/mouse_properties.sv
`timescale 1ns/10ps

module mouseProperties (
  input logic      CLK,
  input logic      RESET,
  input logic      byteReq,
  input logic      byteAck,
  input logic      pktReq,
  input logic      pktAck,
  input logic      curReq,
  input logic      curAck,
  input logic      interruptRaise,
  input logic      busWe,
  input wire [7:0] busData
);

  //////////////////////////////
  // Four-phase handshakes
  //////////////////////////////

  // Req stays up until the receiver answers
  property reqHolds(req, ack);
    @(posedge CLK) disable iff (RESET) (req && !ack) |=> req;
  endproperty

  // Ack stays up while req is still high
  property ackHolds(req, ack);
    @(posedge CLK) disable iff (RESET) (req && ack) |=> ack;
  endproperty

  assert property (reqHolds(byteReq, byteAck)) else $error("byteReq dropped before byteAck");
  assert property (reqHolds(pktReq, pktAck)) else $error("pktReq dropped before pktAck");
  assert property (reqHolds(curReq, curAck)) else $error("curReq dropped before curAck");
  assert property (ackHolds(byteReq, byteAck)) else $error("byteAck fell before byteReq");
  assert property (ackHolds(pktReq, pktAck)) else $error("pktAck fell before pktReq");
  assert property (ackHolds(curReq, curAck)) else $error("curAck fell before curReq");

  //////////////////////////////
  // Reset and bus drive
  //////////////////////////////

  assert property (@(posedge CLK) RESET |=> !interruptRaise)
    else $error("interruptRaise high after reset");

  // A second driver during a write shows up as X on the bus
  assert property (@(posedge CLK) disable iff (RESET) busWe |-> !$isunknown(busData))
    else $error("DUT drives busData during a write");

endmodule

bind mouseDriverTop mouseProperties uProperties (
  .CLK            (CLK),
  .RESET          (RESET),
  .byteReq        (byteReq),
  .byteAck        (byteAck),
  .pktReq         (pktReq),
  .pktAck         (pktAck),
  .curReq         (curReq),
  .curAck         (curAck),
  .interruptRaise (interruptRaise),
  .busWe          (busWe),
  .busData        (busData)
);

//--- tests/mouseDriverTb.sv
`timescale 1ns/10ps

`include "mouse_consts.svh"

module mouseDriverTb;

  localparam int NUM_ROWS       = 11;
  localparam int PS2_HALF       = 4;
  localparam int TIMEOUT_CYCLES = 500;

  // One packet plus the sensitivity written before it
  typedef struct packed {
    logic [7:0] header;
    logic [7:0] dx;
    logic [7:0] dy;
    logic [1:0] sens;
    logic       badParity;
    logic       randomFill;
  } testRow;

  logic       CLK;
  logic       RESET;
  logic       clkMouse;
  logic       dataMouse;
  logic [7:0] busAddr;
  logic       busWe;
  logic       interruptAck;
  logic       interruptRaise;
  logic [7:0] busDrv;
  logic       busDrvEn;
  wire  [7:0] busData;

  testRow     rows [NUM_ROWS];
  integer     seed;
  integer     errors;
  integer     checks;
  integer     row;
  integer     i;
  integer     modelX;
  integer     modelY;
  integer     scaledX;
  integer     scaledY;
  logic [1:0] modelSens;
  logic       modelSticky;
  logic [2:0] modelButtons;
  logic [7:0] modelLastDx;
  logic [7:0] hdr;
  logic [7:0] dxByte;
  logic [7:0] dyByte;
  logic       sawIrq;
  logic       irqArrived;

  // Processor side of the tristate bus
  assign busData = busDrvEn ? busDrv : 8'hzz;

  mouseDriverTop UUT (
    .CLK            (CLK),
    .RESET          (RESET),
    .clkMouse       (clkMouse),
    .dataMouse      (dataMouse),
    .busData        (busData),
    .busAddr        (busAddr),
    .busWe          (busWe),
    .interruptRaise (interruptRaise),
    .interruptAck   (interruptAck)
  );

  always #10 CLK = ~CLK;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // 9-bit delta times the sensitivity factor, floor for the half step
  function automatic integer scaleAxis(input logic sign, input logic [7:0] mag,
                                       input logic ovf, input logic [1:0] s);
    integer raw;
    raw = mag;
    if (sign) raw = raw - 256;
    if (ovf) return 0;
    case (s)
      2'd0:    return (raw >= 0) ? raw / 2 : -((1 - raw) / 2);
      2'd1:    return raw;
      2'd2:    return raw * 2;
      default: return raw * 4;
    endcase
  endfunction

  function automatic integer clampPos(input integer pos, input integer limit);
    if (pos < 0) return 0;
    if (pos > limit) return limit;
    return pos;
  endfunction

  function automatic logic [7:0] saturateDx(input integer d);
    integer v;
    v = d;
    if (v > 127) v = 127;
    if (v < -127) v = -127;
    return v[7:0];
  endfunction

  //////////////////////////////
  // Mouse and bus models
  //////////////////////////////

  // Start, 8 data LSB first, odd parity, stop
  task automatic sendByte(input logic [7:0] value, input logic wrongParity);
    logic [10:0] frame;
    integer      b;
    frame = {1'b1, (~^value) ^ wrongParity, value, 1'b0};
    for (b = 0; b < 11; b++) begin
      dataMouse = frame[b];
      repeat (PS2_HALF) @(negedge CLK);
      clkMouse = 1'b0;
      repeat (PS2_HALF) @(negedge CLK);
      clkMouse = 1'b1;
    end
    dataMouse = 1'b1;
    repeat (2 * PS2_HALF) @(negedge CLK);
  endtask

  task automatic writeBus(input logic [7:0] addr, input logic [7:0] value);
    busAddr  = addr;
    busWe    = 1'b1;
    busDrv   = value;
    busDrvEn = 1'b1;
    @(negedge CLK);
    busWe    = 1'b0;
    busDrvEn = 1'b0;
    busAddr  = 8'h00;
  endtask

  // Address held two cycles, data taken at the end of the second
  task automatic readBus(input logic [7:0] addr, output logic [7:0] value);
    busAddr = addr;
    busWe   = 1'b0;
    repeat (2) @(negedge CLK);
    value   = busData;
    busAddr = 8'h00;
  endtask

  //////////////////////////////
  // Checking and run control
  //////////////////////////////

  task automatic checkValue(input string name, input logic [7:0] got,
                            input logic [7:0] expected);
    checks++;
    if (got !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic checkRegister(input logic [2:0] offset, input string name,
                               input logic [7:0] expected);
    logic [7:0] value;
    readBus(`MOUSE_BASE_ADDR + offset, value);
    checkValue(name, value, expected);
  endtask

  task automatic finishRun();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic waitInterrupt(output logic arrived);
    integer count;
    count = 0;
    while (!interruptRaise && count < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      count++;
    end
    arrived = (interruptRaise === 1'b1);
    if (!arrived) begin
      $display("Timeout: no interrupt arrived for table row %0d", row);
      errors++;
    end
  endtask

  task automatic acknowledgeInterrupt();
    interruptAck = 1'b1;
    @(negedge CLK);
    interruptAck = 1'b0;
    checks++;
    if (interruptRaise !== 1'b0) begin
      $display("mismatch at %0t: interruptRaise got %b expected 0", $time, interruptRaise);
      errors++;
    end
  endtask

  // Header YO XO YS XS 1 M R L
  task automatic fillTable();
    rows[0]  = '{8'h09, 8'h0A, 8'h05, 2'd1, 1'b0, 1'b0};
    rows[1]  = '{8'h0A, 8'h14, 8'h08, 2'd0, 1'b0, 1'b0};
    rows[2]  = '{8'h0C, 8'h05, 8'h03, 2'd2, 1'b0, 1'b0};
    // Odd negative delta at half scale
    rows[3]  = '{8'h18, 8'hFD, 8'h01, 2'd0, 1'b0, 1'b0};
    // Clamp at both maximums, then at zero
    rows[4]  = '{8'h08, 8'h28, 8'h1E, 2'd3, 1'b0, 1'b0};
    rows[5]  = '{8'h38, 8'h80, 8'h80, 2'd3, 1'b0, 1'b0};
    // X overflow, then Y overflow
    rows[6]  = '{8'h48, 8'h32, 8'h0C, 2'd1, 1'b0, 1'b0};
    rows[7]  = '{8'h88, 8'h07, 8'h63, 2'd1, 1'b0, 1'b0};
    // Corrupt header, trailing bytes have bit 3 clear
    rows[8]  = '{8'h09, 8'h02, 8'h04, 2'd1, 1'b1, 1'b0};
    rows[9]  = '{8'h0B, 8'h00, 8'h00, 2'd1, 1'b0, 1'b1};
    rows[10] = '{8'h18, 8'h00, 8'h00, 2'd2, 1'b0, 1'b1};
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    CLK          = 1'b0;
    RESET        = 1'b1;
    clkMouse     = 1'b1;
    dataMouse    = 1'b1;
    busAddr      = 8'h00;
    busWe        = 1'b0;
    interruptAck = 1'b0;
    busDrv       = 8'h00;
    busDrvEn     = 1'b0;
    seed         = 32'hc64f;
    errors       = 0;
    checks       = 0;
    modelX       = 0;
    modelY       = 0;
    modelSens    = `SENS_RESET;
    modelSticky  = 1'b0;
    fillTable();

    repeat (4) @(negedge CLK);
    RESET = 1'b0;
    @(negedge CLK);

    // Reset state
    checks++;
    if (interruptRaise !== 1'b0) begin
      $display("mismatch at %0t: interruptRaise got %b expected 0", $time, interruptRaise);
      errors++;
    end
    checkRegister(3'd1, "posX", 8'd0);
    checkRegister(3'd2, "posY", 8'd0);
    checkRegister(3'd4, "sens", {6'b000000, modelSens});
    checkRegister(3'd5, "reserved", 8'd0);

    // First address past the bank
    busAddr = `MOUSE_BASE_ADDR + `MOUSE_NUM_REGS;
    repeat (2) @(negedge CLK);
    checks++;
    if (busData !== 8'hzz) begin
      $display("busData is driven for an address outside the register bank");
      errors++;
    end
    busAddr = 8'h00;

    for (row = 0; row < NUM_ROWS; row++) begin
      hdr    = rows[row].header;
      dxByte = rows[row].dx;
      dyByte = rows[row].dy;
      if (rows[row].randomFill) begin
        dxByte = $random(seed);
        dyByte = $random(seed);
      end

      // Sensitivity goes in before the packet
      writeBus(`MOUSE_BASE_ADDR + 8'd4, {6'b000000, rows[row].sens});
      modelSens = rows[row].sens;
      checkRegister(3'd4, "sens", {6'b000000, modelSens});

      sendByte(hdr, rows[row].badParity);
      sendByte(dxByte, 1'b0);
      sendByte(dyByte, 1'b0);

      if (rows[row].badParity) begin
        modelSticky = 1'b1;
        sawIrq      = 1'b0;
        for (i = 0; i < 100; i++) begin
          @(negedge CLK);
          if (interruptRaise) sawIrq = 1'b1;
        end
        checks++;
        if (sawIrq) begin
          $display("An interrupt was raised for a packet with a bad header parity");
          errors++;
        end
      end else begin
        scaledX      = scaleAxis(hdr[4], dxByte, hdr[6], modelSens);
        scaledY      = scaleAxis(hdr[5], dyByte, hdr[7], modelSens);
        modelX       = clampPos(modelX + scaledX, `SCREEN_X_MAX);
        modelY       = clampPos(modelY + scaledY, `SCREEN_Y_MAX);
        modelButtons = hdr[2:0];
        modelLastDx  = saturateDx(scaledX);

        waitInterrupt(irqArrived);
        if (irqArrived) begin
          checkRegister(3'd0, "status", {modelSticky, 4'b0000, modelButtons});
          checkRegister(3'd1, "posX", modelX[7:0]);
          checkRegister(3'd2, "posY", modelY[7:0]);
          checkRegister(3'd3, "lastDx", modelLastDx);
          acknowledgeInterrupt();
        end
      end
    end

    // Position registers are read only
    writeBus(`MOUSE_BASE_ADDR + 8'd1, 8'h55);
    checkRegister(3'd1, "posX", modelX[7:0]);
    checkRegister(3'd4, "sens", {6'b000000, modelSens});

    finishRun();
  end

endmodule

//--- project.f
+incdir+include
src/mousePkg.sv
src/ps2Receiver.sv
src/packetAssembler.sv
src/positionTracker.sv
src/mouseBusRegs.sv
src/mouseDriverTop.sv
tests/mouse_properties.sv
tests/mouseDriverTb.sv
